/* hl2_params.svh */
`ifndef HL2_PARAMS_SVH
`define HL2_PARAMS_SVH

// Relay settle time in TR_SETTLE before RF is let out
`define HL_TR_SETTLE_CYCLES 4

// Clock cycles per unit of the host hang time
`define HL_HANG_TICK_CYCLES 16

// Half period of the run heartbeat
`define HL_HEARTBEAT_CYCLES 64

// Overload LEDs stay lit this long after the last qualifying sample
`define HL_LED_HOLD_CYCLES 32

// Three quarters of full scale for a 12-bit signed sample
`define HL_ADC75_LEVEL 1536

// Host register map
`define HL_REG_CTRL 4'd0
`define HL_REG_HANG 4'd1
`define HL_REG_FAN  4'd2

`endif

/* hl2_pkg.sv */
`default_nettype none

package hl2_pkg;

  // Host command bus
  typedef logic [3:0] cmd_addr_t;
  typedef logic [7:0] cmd_data_t;

  // Fan duty as high cycles out of every 256
  typedef logic [7:0] duty_t;

  // PTT hang time in units of HL_HANG_TICK_CYCLES
  typedef logic [7:0] hang_t;

  // One parallel sample from the AD9866 receive path, two's complement
  typedef logic signed [11:0] adc_sample_t;

  // Transmit/receive sequencer states
  typedef enum logic [1:0] {
    RX         = 2'd0,
    TR_SETTLE  = 2'd1,
    TX         = 2'd2,
    HANG       = 2'd3
  } txrx_state_t;

endpackage

`default_nettype wire

/* hl2_cfg_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Host configuration as decoded by the register file
interface hl2_cfg_if;

  logic              host_ptt;
  logic              pa_enable;
  logic              run;
  hl2_pkg::hang_t    hang_time;
  hl2_pkg::duty_t    fan_duty;

  modport regs (
    output host_ptt,
    output pa_enable,
    output run,
    output hang_time,
    output fan_duty
  );

  modport txrx (
    input host_ptt,
    input pa_enable,
    input hang_time
  );

  modport fan (
    input fan_duty
  );

  modport leds (
    input run
  );

endinterface

`default_nettype wire

/* hl2_cmd_regs.sv */
`timescale 1ns/1ns
`default_nettype none
`include "hl2_params.svh"

module hl2_cmd_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cmd_we,
  input  hl2_pkg::cmd_addr_t  cmd_addr,
  input  hl2_pkg::cmd_data_t  cmd_data,
  hl2_cfg_if.regs             cfg
);

  // Bit positions inside the control register
  localparam int CTRL_PTT_BIT = 0;
  localparam int CTRL_PA_BIT  = 1;
  localparam int CTRL_RUN_BIT = 2;
  localparam int CTRL_W       = 3;

  logic [CTRL_W-1:0] ctrl_q;
  hl2_pkg::hang_t    hang_q;
  hl2_pkg::duty_t    fan_q;

  // Writes take effect on the edge that samples the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= '0;
      hang_q <= '0;
      fan_q  <= '0;
    end else if (cmd_we) begin
      case (cmd_addr)
        `HL_REG_CTRL: begin
          ctrl_q <= cmd_data[CTRL_W-1:0];
        end
        `HL_REG_HANG: begin
          hang_q <= cmd_data;
        end
        `HL_REG_FAN: begin
          fan_q <= cmd_data;
        end
        default: begin
          // Unmapped addresses are silently dropped
        end
      endcase
    end
  end

  assign cfg.host_ptt  = ctrl_q[CTRL_PTT_BIT];
  assign cfg.pa_enable = ctrl_q[CTRL_PA_BIT];
  assign cfg.run       = ctrl_q[CTRL_RUN_BIT];
  assign cfg.hang_time = hang_q;
  assign cfg.fan_duty  = fan_q;

  // The host side must present a defined address with every strobe
  a_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd_we |-> !$isunknown(cmd_addr)
  ) else $error("hl2_cmd_regs: unknown cmd_addr with cmd_we high");

endmodule

`default_nettype wire

/* hl2_txrx_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "hl2_params.svh"

module hl2_txrx_ctrl (
  input  logic      clk,
  input  logic      rst_n,
  hl2_cfg_if.txrx   cfg,
  input  logic      key,
  input  logic      ptt,
  input  logic      inhibit,
  output logic      pa_tr,
  output logic      pa_en,
  output logic      txquiet_n
);

  localparam int unsigned SETTLE   = `HL_TR_SETTLE_CYCLES;
  localparam int unsigned TICK     = `HL_HANG_TICK_CYCLES;
  localparam int          SETTLE_W = (SETTLE > 1) ? $clog2(SETTLE) : 1;
  localparam int          HANG_W   = $bits(hl2_pkg::hang_t) + $clog2(TICK);

  hl2_pkg::txrx_state_t state;
  hl2_pkg::txrx_state_t state_nxt;
  logic [SETTLE_W-1:0]  settle_cnt;
  logic [HANG_W-1:0]    hang_cnt;
  logic [HANG_W-1:0]    hang_total;
  logic                 req;
  logic                 settle_done;
  logic                 hang_done;

  // Any source may key the radio, but inhibit vetoes all of them
  assign req         = (cfg.host_ptt | key | ptt) & ~inhibit;
  assign hang_total  = HANG_W'(cfg.hang_time) * HANG_W'(TICK);
  assign settle_done = (settle_cnt == SETTLE_W'(SETTLE - 1));
  assign hang_done   = (hang_cnt == '0);

  always_comb begin
    state_nxt = state;
    case (state)
      hl2_pkg::RX: begin
        if (req) state_nxt = hl2_pkg::TR_SETTLE;
      end
      hl2_pkg::TR_SETTLE: begin
        // The relay has to finish moving even if the request goes away
        if (settle_done) state_nxt = hl2_pkg::TX;
      end
      hl2_pkg::TX: begin
        if (!req) state_nxt = (hang_total == '0) ? hl2_pkg::RX : hl2_pkg::HANG;
      end
      hl2_pkg::HANG: begin
        if (req) begin
          state_nxt = hl2_pkg::TX;
        end else if (hang_done) begin
          state_nxt = hl2_pkg::RX;
        end
      end
      default: begin
        state_nxt = hl2_pkg::RX;
      end
    endcase
    if (inhibit) state_nxt = hl2_pkg::RX;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= hl2_pkg::RX;
      settle_cnt <= '0;
      hang_cnt   <= '0;
    end else begin
      state <= state_nxt;
      if (state == hl2_pkg::TR_SETTLE) begin
        settle_cnt <= settle_cnt + 1'b1;
      end else begin
        settle_cnt <= '0;
      end
      // Reload on every TX cycle so the hang starts from the latest setting
      if (state == hl2_pkg::TX) begin
        hang_cnt <= hang_total - 1'b1;
      end else if (state == hl2_pkg::HANG && !hang_done) begin
        hang_cnt <= hang_cnt - 1'b1;
      end
    end
  end

  assign pa_tr     = (state != hl2_pkg::RX);
  assign txquiet_n = (state == hl2_pkg::TX);
  assign pa_en     = cfg.pa_enable & pa_tr;

  // RF only leaves the transceiver once the relay has been over for the settle time
  a_settled: assert property (
    @(posedge clk) disable iff (!rst_n)
    txquiet_n |-> (pa_tr && $past(pa_tr, `HL_TR_SETTLE_CYCLES))
  ) else $error("hl2_txrx_ctrl: txquiet_n high without a settled relay");

  a_inhibit: assert property (
    @(posedge clk) disable iff (!rst_n)
    inhibit |=> !txquiet_n
  ) else $error("hl2_txrx_ctrl: transmit not stopped after inhibit");

endmodule

`default_nettype wire

/* hl2_fan_pwm.sv */
`timescale 1ns/1ns
`default_nettype none

module hl2_fan_pwm (
  input  logic     clk,
  input  logic     rst_n,
  hl2_cfg_if.fan   cfg,
  output logic     fan_pwm
);

  // Period is fixed at 256 cycles by the width of the duty register
  hl2_pkg::duty_t pwm_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
    end
  end

  // A duty of 0 keeps the fan off and 255 leaves one low cycle per period
  assign fan_pwm = (pwm_cnt < cfg.fan_duty);

endmodule

`default_nettype wire

/* hl2_status_leds.sv */
`timescale 1ns/1ns
`default_nettype none
`include "hl2_params.svh"

module hl2_status_leds (
  input  logic                  clk,
  input  logic                  rst_n,
  hl2_cfg_if.leds               cfg,
  input  hl2_pkg::adc_sample_t  adc_sample,
  output logic                  led_run,
  output logic                  led_adc75,
  output logic                  led_adc100
);

  localparam int unsigned HB     = `HL_HEARTBEAT_CYCLES;
  localparam int          HB_W   = (HB > 1) ? $clog2(HB) : 1;
  localparam int unsigned HOLD   = `HL_LED_HOLD_CYCLES;
  localparam int          HOLD_W = $clog2(HOLD + 1);
  localparam int          ADC_W  = $bits(hl2_pkg::adc_sample_t);

  localparam hl2_pkg::adc_sample_t LVL75    = hl2_pkg::adc_sample_t'(`HL_ADC75_LEVEL);
  localparam hl2_pkg::adc_sample_t FULL_POS = {1'b0, {(ADC_W - 1){1'b1}}};
  localparam hl2_pkg::adc_sample_t FULL_NEG = {1'b1, {(ADC_W - 1){1'b0}}};

  logic [HB_W-1:0]   hb_cnt;
  logic [1:0]        hit;
  logic [HOLD_W-1:0] hold_cnt [2];

  // Heartbeat only runs while the host has the radio running
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hb_cnt  <= '0;
      led_run <= 1'b0;
    end else if (!cfg.run) begin
      hb_cnt  <= '0;
      led_run <= 1'b0;
    end else if (hb_cnt == HB_W'(HB - 1)) begin
      hb_cnt  <= '0;
      led_run <= ~led_run;
    end else begin
      hb_cnt <= hb_cnt + 1'b1;
    end
  end

  // Index 0 is the 75 % detector, index 1 the clipping detector
  assign hit[0] = (adc_sample >= LVL75) || (adc_sample <= -LVL75);
  assign hit[1] = (adc_sample == FULL_POS) || (adc_sample == FULL_NEG);

  for (genvar i = 0; i < 2; i++) begin : g_hold
    // Each new hit restarts the stretch
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        hold_cnt[i] <= '0;
      end else if (hit[i]) begin
        hold_cnt[i] <= HOLD_W'(HOLD);
      end else if (hold_cnt[i] != '0) begin
        hold_cnt[i] <= hold_cnt[i] - 1'b1;
      end
    end
  end

  assign led_adc75  = (hold_cnt[0] != '0);
  assign led_adc100 = (hold_cnt[1] != '0);

endmodule

`default_nettype wire

/* hl2_core.sv */
`timescale 1ns/1ns
`default_nettype none

module hl2_core (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_we,
  input  hl2_pkg::cmd_addr_t    cmd_addr,
  input  hl2_pkg::cmd_data_t    cmd_data,
  input  hl2_pkg::adc_sample_t  adc_sample,
  input  logic                  io_phone_tip,
  input  logic                  io_phone_ring,
  input  logic                  io_tx_inhibit,
  output logic                  pa_tr,
  output logic                  pa_en,
  output logic                  txquiet_n,
  output logic                  led_run,
  output logic                  led_tx,
  output logic                  led_adc75,
  output logic                  led_adc100,
  output logic                  fan_pwm
);

  // Order of the pin bits is tip, ring, inhibit
  logic [2:0]            pin_meta;
  logic [2:0]            pin_sync;
  hl2_pkg::adc_sample_t  adc_q;

  // The pins idle high, so they are flipped on the way in and reset to idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pin_meta <= '0;
      pin_sync <= '0;
      adc_q    <= '0;
    end else begin
      pin_meta <= ~{io_phone_tip, io_phone_ring, io_tx_inhibit};
      pin_sync <= pin_meta;
      adc_q    <= adc_sample;
    end
  end

  hl2_cfg_if cfg ();

  hl2_cmd_regs hl2_cmd_regs_i (
    .clk      (clk     ),
    .rst_n    (rst_n   ),
    .cmd_we   (cmd_we  ),
    .cmd_addr (cmd_addr),
    .cmd_data (cmd_data),
    .cfg      (cfg     )
  );

  hl2_txrx_ctrl hl2_txrx_ctrl_i (
    .clk       (clk        ),
    .rst_n     (rst_n      ),
    .cfg       (cfg        ),
    .key       (pin_sync[2]),
    .ptt       (pin_sync[1]),
    .inhibit   (pin_sync[0]),
    .pa_tr     (pa_tr      ),
    .pa_en     (pa_en      ),
    .txquiet_n (txquiet_n  )
  );

  hl2_fan_pwm hl2_fan_pwm_i (
    .clk     (clk    ),
    .rst_n   (rst_n  ),
    .cfg     (cfg    ),
    .fan_pwm (fan_pwm)
  );

  hl2_status_leds hl2_status_leds_i (
    .clk        (clk       ),
    .rst_n      (rst_n     ),
    .cfg        (cfg       ),
    .adc_sample (adc_q     ),
    .led_run    (led_run   ),
    .led_adc75  (led_adc75 ),
    .led_adc100 (led_adc100)
  );

  // TX LED shows the relay position
  assign led_tx = pa_tr;

endmodule

`default_nettype wire

/* hermeslite.sv */
`timescale 1ns/1ns
`default_nettype none

module hermeslite (
  // Clock and reset
  input  logic                  rffe_ad9866_clk76p8  ,
  input  logic                  rst_n                ,
  // Host command stream
  input  logic                  cmd_we               ,
  input  hl2_pkg::cmd_addr_t    cmd_addr             ,
  input  hl2_pkg::cmd_data_t    cmd_data             ,
  // RF frontend
  input  hl2_pkg::adc_sample_t  rffe_adc_sample      ,
  output logic                  rffe_ad9866_txquiet_n,
  // IO
  input  logic                  io_phone_tip         ,
  input  logic                  io_phone_ring        ,
  input  logic                  io_cn8               ,
  output logic                  io_led_d2            ,
  output logic                  io_led_d3            ,
  output logic                  io_led_d4            ,
  output logic                  io_led_d5            ,
  output logic                  io_cn4_6             ,
  // PA
  output logic                  pa_tr                ,
  output logic                  pa_en
);

  // CN8 is the external TX inhibit and CN4 pin 6 drives the fan
  hl2_core hl2_core_i (
    .clk           (rffe_ad9866_clk76p8  ),
    .rst_n         (rst_n                ),
    .cmd_we        (cmd_we               ),
    .cmd_addr      (cmd_addr             ),
    .cmd_data      (cmd_data             ),
    .adc_sample    (rffe_adc_sample      ),
    .io_phone_tip  (io_phone_tip         ),
    .io_phone_ring (io_phone_ring        ),
    .io_tx_inhibit (io_cn8               ),
    .pa_tr         (pa_tr                ),
    .pa_en         (pa_en                ),
    .txquiet_n     (rffe_ad9866_txquiet_n),
    .led_run       (io_led_d2            ),
    .led_tx        (io_led_d3            ),
    .led_adc75     (io_led_d4            ),
    .led_adc100    (io_led_d5            ),
    .fan_pwm       (io_cn4_6             )
  );

endmodule

`default_nettype wire

/* tb_hermeslite.sv */
`timescale 1ns/1ns
`default_nettype none
`include "hl2_params.svh"

module tb_hermeslite;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int HOLD = `HL_LED_HOLD_CYCLES;

  logic                 rffe_ad9866_clk76p8 = 1'b0;
  logic                 rst_n, cmd_we, io_phone_tip, io_phone_ring, io_cn8;
  hl2_pkg::cmd_addr_t   cmd_addr;
  hl2_pkg::cmd_data_t   cmd_data;
  hl2_pkg::adc_sample_t rffe_adc_sample;
  logic                 pa_tr, pa_en, rffe_ad9866_txquiet_n, io_cn4_6;
  logic                 io_led_d2, io_led_d3, io_led_d4, io_led_d5;

  // Reference model as it stands after the latest rising edge
  hl2_pkg::txrx_state_t m_state = hl2_pkg::RX;
  hl2_pkg::adc_sample_t m_adc = '0;
  logic [2:0]           m_meta = '0, m_sync = '0;
  logic [7:0]           m_hang = '0, m_fan = '0;
  logic                 m_ptt = 1'b0, m_pa = 1'b0, m_run = 1'b0, m_led_run = 1'b0;
  int                   m_settle_left = 0, m_hang_left = 0, m_pwm = 0, m_hb = 0;
  int                   m_hold75 = 0, m_hold100 = 0;
  // Chance out of 16 of a near full scale sample where 0 keeps the ADC silent
  int                   adc_mode = 0;
  int                   cycles = 0;

  hermeslite UUT (.*);

  always #20 rffe_ad9866_clk76p8 = ~rffe_ad9866_clk76p8;

  always @(posedge rffe_ad9866_clk76p8) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  task automatic expect_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, got);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_outputs();
    logic tr;
    tr = (m_state != hl2_pkg::RX);
    expect_val("pa_tr", pa_tr, tr);
    expect_val("io_led_d3", io_led_d3, tr);
    expect_val("rffe_ad9866_txquiet_n", rffe_ad9866_txquiet_n, m_state == hl2_pkg::TX);
    expect_val("pa_en", pa_en, m_pa & tr);
    expect_val("io_cn4_6", io_cn4_6, m_pwm < int'(m_fan));
    expect_val("io_led_d2", io_led_d2, m_led_run);
    expect_val("io_led_d4", io_led_d4, m_hold75 != 0);
    expect_val("io_led_d5", io_led_d5, m_hold100 != 0);
  endtask

  // Advance the model by one rising edge with the inputs now on the pins
  task automatic model_step();
    logic req;
    logic clip;
    int   hang_total, mag;
    req = (m_ptt | m_sync[2] | m_sync[1]) & ~m_sync[0];
    hang_total = int'(m_hang) * `HL_HANG_TICK_CYCLES;
    case (m_state)
      hl2_pkg::RX: begin
        m_settle_left = `HL_TR_SETTLE_CYCLES;
        if (req) m_state = hl2_pkg::TR_SETTLE;
      end
      hl2_pkg::TR_SETTLE: begin
        m_settle_left--;
        if (m_settle_left == 0) m_state = hl2_pkg::TX;
      end
      hl2_pkg::TX: begin
        m_hang_left = hang_total;
        if (!req) m_state = (hang_total == 0) ? hl2_pkg::RX : hl2_pkg::HANG;
      end
      hl2_pkg::HANG: begin
        m_hang_left--;
        if (req) begin
          m_state = hl2_pkg::TX;
        end else if (m_hang_left == 0) begin
          m_state = hl2_pkg::RX;
        end
      end
    endcase
    if (m_sync[0]) m_state = hl2_pkg::RX;

    m_pwm = (m_pwm + 1) % 256;
    if (!m_run) begin
      m_hb = 0;
      m_led_run = 1'b0;
    end else begin
      m_hb++;
      if (m_hb == `HL_HEARTBEAT_CYCLES) begin
        m_hb = 0;
        m_led_run = ~m_led_run;
      end
    end

    // Only the two full-scale codes count as clipping
    mag = int'(m_adc);
    clip = (mag == 2047) || (mag == -2048);
    if (mag < 0) mag = -mag;
    m_hold75 = (mag >= `HL_ADC75_LEVEL) ? HOLD : ((m_hold75 > 0) ? m_hold75 - 1 : 0);
    m_hold100 = clip ? HOLD : ((m_hold100 > 0) ? m_hold100 - 1 : 0);

    m_sync = m_meta;
    m_meta = ~{io_phone_tip, io_phone_ring, io_cn8};
    m_adc = rffe_adc_sample;
    if (cmd_we && cmd_addr == `HL_REG_CTRL) {m_run, m_pa, m_ptt} = cmd_data[2:0];
    if (cmd_we && cmd_addr == `HL_REG_HANG) m_hang = cmd_data;
    if (cmd_we && cmd_addr == `HL_REG_FAN) m_fan = cmd_data;
  endtask

  function automatic hl2_pkg::adc_sample_t pick_sample();
    int mag;
    if (adc_mode == 0) return '0;
    if (int'($urandom_range(15)) < adc_mode) begin
      mag = int'($urandom_range(2048, 1500));
    end else begin
      mag = int'($urandom_range(1400));
    end
    if ($urandom_range(1) == 1) begin
      mag = -mag;
    end else if (mag == 2048) begin
      mag = 2047;
    end
    return hl2_pkg::adc_sample_t'(mag);
  endfunction

  // Runs on a falling edge to check the last rising edge and drive the next one
  task automatic step();
    check_outputs();
    rffe_adc_sample = pick_sample();
    model_step();
    @(negedge rffe_ad9866_clk76p8);
    cmd_we = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  task automatic write_reg(input hl2_pkg::cmd_addr_t addr, input hl2_pkg::cmd_data_t data);
    cmd_we = 1'b1;
    cmd_addr = addr;
    cmd_data = data;
    step();
  endtask

  initial begin
    int duty;
    void'($urandom(75));
    rst_n = 1'b0;
    cmd_we = 1'b0;
    cmd_addr = '0;
    cmd_data = '0;
    rffe_adc_sample = '0;
    // Key, PTT and inhibit pins idle high
    io_phone_tip = 1'b1;
    io_phone_ring = 1'b1;
    io_cn8 = 1'b1;
    repeat (3) @(posedge rffe_ad9866_clk76p8);
    @(negedge rffe_ad9866_clk76p8);
    rst_n = 1'b1;
    expect_val("outputs after reset", {pa_tr, pa_en, rffe_ad9866_txquiet_n, io_cn4_6,
               io_led_d2, io_led_d3, io_led_d4, io_led_d5}, '0);
    idle(10);

    // Fan duty at both ends and in between with unmapped writes mixed in
    adc_mode = 1;
    for (int i = 0; i < 4; i++) begin
      duty = (i == 0) ? 0 : (i == 1) ? 255 : int'($urandom_range(254, 1));
      write_reg(`HL_REG_FAN, 8'(duty));
      repeat (3) begin
        idle($urandom_range(60, 20));
        write_reg(4'($urandom_range(15, 3)), 8'($urandom));
      end
      idle(200);
    end

    // Key and PTT presses where short gaps re-key while the hang timer runs
    for (int i = 0; i < 12; i++) begin
      write_reg(`HL_REG_HANG, 8'($urandom_range(3)));
      if ($urandom_range(1) == 1) begin
        io_phone_tip = 1'b0;
      end else begin
        io_phone_ring = 1'b0;
      end
      idle($urandom_range(30, 5));
      io_phone_tip = 1'b1;
      io_phone_ring = 1'b1;
      idle($urandom_range(70));
    end

    // Inhibit pulses land while PTT is held
    write_reg(`HL_REG_HANG, 8'd2);
    for (int i = 0; i < 10; i++) begin
      io_phone_ring = 1'b0;
      idle($urandom_range(20));
      io_cn8 = 1'b0;
      idle($urandom_range(15, 3));
      io_cn8 = 1'b1;
      idle($urandom_range(10));
      io_phone_ring = 1'b1;
      idle($urandom_range(50, 20));
    end

    // Host PTT with a random PA enable that also changes while idle
    for (int i = 0; i < 8; i++) begin
      write_reg(`HL_REG_CTRL, {6'd0, 1'($urandom), 1'b1});
      idle($urandom_range(30, 10));
      write_reg(`HL_REG_CTRL, {6'd0, 1'($urandom), 1'b0});
      idle($urandom_range(60, 5));
    end

    // Overload bursts with the heartbeat running, stopped and restarted
    write_reg(`HL_REG_CTRL, 8'h04);
    for (int i = 0; i < 12; i++) begin
      if (i == 6) write_reg(`HL_REG_CTRL, 8'h00);
      if (i == 8) write_reg(`HL_REG_CTRL, 8'h04);
      adc_mode = 12;
      idle($urandom_range(12, 2));
      adc_mode = 1;
      idle($urandom_range(60, 20));
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
hl2_pkg.sv
hl2_cfg_if.sv
hl2_cmd_regs.sv
hl2_txrx_ctrl.sv
hl2_fan_pwm.sv
hl2_status_leds.sv
hl2_core.sv
hermeslite.sv
tb_hermeslite.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and scan the simulation log for the verdict
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_hermeslite -f sim.f \
  && ./obj_dir/Vtb_hermeslite > sim.log 2>&1 \
  || echo "Build or simulation returned an error" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation did not pass"; exit 1; }
echo "Simulation passed"
